// File: tb.f
+incdir+rtl
rtl/slurm16_cpu_pkg.sv
rtl/slurm16_mem_pkg.sv
rtl/slurm16_mem_if.sv
rtl/slurm16_memory_bank.sv
rtl/slurm16_memory_arbiter.sv
rtl/slurm16_cpu_memory_interface.sv
rtl/slurm16_memory_top.sv
test/tb_checker.sv
test/tb.sv

// File: Bender.yml
package:
  name: slurm16_memory

export_include_dirs:
  - rtl

sources:
  - rtl/slurm16_cpu_pkg.sv
  - rtl/slurm16_mem_pkg.sv
  - rtl/slurm16_mem_if.sv
  - rtl/slurm16_memory_bank.sv
  - rtl/slurm16_memory_arbiter.sv
  - rtl/slurm16_cpu_memory_interface.sv
  - rtl/slurm16_memory_top.sv
  - target: test
    files:
      - test/tb_checker.sv
      - test/tb.sv

// File: test/tb.sv
// slurm16 memory system testbench
// Plays the CPU pipeline and the outside agent with seeded random
// fetch, load and store traffic, halt/wake pulses and bank busy levels

`timescale 1ns/1ps

`include "slurm16_cfg.svh"

module tb;

	localparam int  AW           = `SLURM16_ADDRESS_BITS;
	localparam int  PERIOD       = 100;
	localparam int  RESET_CYCLES = 10;
	localparam int  STIM_CYCLES  = 4000;
	localparam time TIMEOUT      = STIM_CYCLES * 4 * PERIOD;

	logic                      CLK, RSTb;
	logic                      load_memory, store_memory, halt, wake;
	logic [AW-1:0]             pc, load_store_address, store_memory_data;
	slurm16_mem_pkg::wr_mask_t store_memory_wr_mask, memory_wr_mask, memory_wr_mask_delayed;
	logic [`SLURM16_BANKS-1:0] bank_busy;
	logic                      is_executing, is_fetching, memory_is_instruction;
	logic                      stall_memory_pipeline_stage3;
	logic [AW-1:0]             memory_address_prev_plus_two, memory_address;
	logic                      memory_valid, memory_ready, memory_wr;
	logic [`SLURM16_BITS-1:0]  memory_out, memory_rdata;
	int                        checks, value_errors, rule_errors;

	slurm16_memory_top DUT (.*);

	tb_checker CHECK (.*);

	// Even byte address in the given bank
	function automatic logic [AW-1:0] even_address(input logic bank);
		logic [AW-1:0] a;
		a         = $urandom;
		a[0]      = 1'b0;
		a[AW-1]   = bank;
		return a;
	endfunction

	task automatic drive_cycle();
		int unsigned kind;
		kind         = $urandom % 16;
		load_memory  = (kind < 3);
		store_memory = (kind >= 3 && kind < 6);
		pc           = even_address(($urandom % 8 == 0) ? ~pc[AW-1] : pc[AW-1]);  // Rare bank hop
		load_store_address   = even_address($urandom % 2);
		store_memory_data    = $urandom;
		store_memory_wr_mask = $urandom % 4;
		halt = ($urandom % 40 == 0);
		wake = ($urandom % 6 == 0);
		for (int b = 0; b < `SLURM16_BANKS; b++)
			bank_busy[b] = ($urandom % 4 == 0);  // Outside agent holds a bank
	endtask

	initial begin
		CLK = 1'b0;
		forever #(PERIOD / 2) CLK = ~CLK;
	end

	initial begin
		#(TIMEOUT);
		$display("watchdog expired before the run completed");
		$display("ERRORS FOUND");
		$finish;
	end

	initial begin
		RSTb                 = 1'b0;
		load_memory          = 1'b0;
		store_memory         = 1'b0;
		halt                 = 1'b0;
		wake                 = 1'b0;
		pc                   = '0;
		load_store_address   = '0;
		store_memory_data    = '0;
		store_memory_wr_mask = 2'b11;
		bank_busy            = '0;
		void'($urandom(32'hcb6e_c027));
		repeat (RESET_CYCLES) @(negedge CLK);
		RSTb = 1'b1;
		repeat (STIM_CYCLES) begin
			@(negedge CLK);
			drive_cycle();
		end
		@(negedge CLK);
		load_memory  = 1'b0;  // Quiet the CPU side and release the banks
		store_memory = 1'b0;
		halt         = 1'b0;
		bank_busy    = '0;
		wake         = 1'b1;
		@(negedge CLK);
		wake = 1'b0;
		while (!is_executing)
			@(negedge CLK);
		repeat (2) @(negedge CLK);  // Last read data lands
		$display("closing: %0d checks, %0d value errors, %0d rule errors",
			checks, value_errors, rule_errors);
		if (value_errors + rule_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

// File: test/tb_checker.sv
// slurm16 memory system checker
// Watches the top-level ports, keeps a word model of both banks with the
// same aliasing as the banks, and counts value and bus-rule errors

`timescale 1ns/1ps

`include "slurm16_cfg.svh"

module tb_checker (
	input  logic                             CLK,
	input  logic                             RSTb,
	input  logic                             halt,
	input  logic                             wake,
	input  logic [`SLURM16_BANKS-1:0]        bank_busy,
	input  logic                             is_executing,
	input  logic                             is_fetching,
	input  logic                             memory_is_instruction,
	input  logic                             stall_memory_pipeline_stage3,
	input  slurm16_mem_pkg::wr_mask_t        memory_wr_mask_delayed,
	input  logic [`SLURM16_ADDRESS_BITS-1:0] memory_address,
	input  logic [`SLURM16_ADDRESS_BITS-1:0] memory_address_prev_plus_two,
	input  logic                             memory_valid,
	input  logic                             memory_ready,
	input  logic                             memory_wr,
	input  slurm16_mem_pkg::wr_mask_t        memory_wr_mask,
	input  logic [`SLURM16_BITS-1:0]         memory_out,
	input  logic [`SLURM16_BITS-1:0]         memory_rdata,
	output int                               checks,
	output int                               value_errors,
	output int                               rule_errors
);

	localparam int AW        = `SLURM16_ADDRESS_BITS;
	localparam int WORD_BITS = $clog2(`SLURM16_BANK_WORDS);

	logic [`SLURM16_BITS-1:0] model [`SLURM16_BANKS][`SLURM16_BANK_WORDS];
	logic [`SLURM16_BITS-1:0] read_expect;   // Word due on memory_rdata
	logic [AW-1:0]            last_address;  // Word address of the previous cycle
	slurm16_mem_pkg::bank_t   bank;
	logic [WORD_BITS-1:0]     word;
	slurm16_mem_pkg::wr_mask_t mask_expect;  // Mask due on memory_wr_mask_delayed
	logic                     read_pending, last_known, was_reset, halted;
	logic                     mask_known;
	logic                     wait_due;      // Refused request outside execution
	logic                     hold_due;      // Address must not move this cycle
	int                       halt_age;      // Cycles since halt was taken

	task automatic compare(input string name, input logic [AW-1:0] expected,
			input logic [AW-1:0] actual);
		checks++;
		if (actual !== expected) begin
			value_errors++;
			$display("error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	task automatic report_rule(input string what);
		rule_errors++;
		$display("bus rule broken at %0t ns: %s", $time, what);
	endtask

	// Word after a write of new under the byte enables
	function automatic logic [`SLURM16_BITS-1:0] masked_write(
			input logic [`SLURM16_BITS-1:0] old, input logic [`SLURM16_BITS-1:0] data,
			input slurm16_mem_pkg::wr_mask_t mask);
		logic [`SLURM16_BITS-1:0] result;
		result = old;
		for (int b = 0; b < `SLURM16_BITS / 8; b++) begin
			if (mask[b])
				result[b*8 +: 8] = data[b*8 +: 8];
		end
		return result;
	endfunction

	initial begin
		foreach (model[b, w])
			model[b][w] = '0;  // Banks start cleared
		checks       = 0;
		value_errors = 0;
		rule_errors  = 0;
		read_pending = 1'b0;
		last_known   = 1'b0;
		was_reset    = 1'b0;
		halted       = 1'b0;
		mask_known   = 1'b0;
		wait_due     = 1'b0;
		hold_due     = 1'b0;
		halt_age     = 0;
	end

	always @(posedge CLK) begin
		if (!RSTb || was_reset) begin
			if (memory_valid !== 1'b0 || memory_wr !== 1'b0 || is_executing !== 1'b0)
				report_rule("bus active or executing in reset or the cycle after");
		end
		was_reset = !RSTb;

		// Stall or back-pressure in the previous cycle
		if (hold_due) begin
			compare("memory_address", last_address, memory_address);
			if (wait_due && (memory_valid !== 1'b1 || is_executing !== 1'b0))
				report_rule("wait state left without a grant");
		end

		if (last_known)
			compare("memory_address_prev_plus_two", {last_address[AW-2:0], 1'b0} + 2,
				memory_address_prev_plus_two);
		last_address = memory_address;
		last_known   = !$isunknown(memory_address);

		if (mask_known)
			compare("memory_wr_mask_delayed", mask_expect, memory_wr_mask_delayed);
		if (!RSTb)
			mask_known = 1'b0;
		else if (!stall_memory_pipeline_stage3) begin
			mask_expect = memory_wr_mask;
			mask_known  = 1'b1;
		end

		wait_due = RSTb && memory_valid && !memory_ready && !is_executing;
		hold_due = wait_due || (RSTb && stall_memory_pipeline_stage3);

		if (RSTb) begin
			bank = memory_address[AW-2];  // Bank bit of the word address
			word = memory_address[WORD_BITS-1:0];
			if ($isunknown(is_fetching) || $isunknown(memory_is_instruction))
				report_rule("status output unknown after reset");
			if (memory_wr && !memory_valid)
				report_rule("write strobe without a request");
			if (memory_ready && bank_busy[bank])
				report_rule("request granted to a busy bank");
			if (read_pending)
				compare("memory_rdata", read_expect, memory_rdata);
			read_pending = memory_valid && memory_ready && !memory_wr;
			if (read_pending)
				read_expect = model[bank][word];
			if (memory_valid && memory_ready && memory_wr)
				model[bank][word] = masked_write(model[bank][word], memory_out, memory_wr_mask);

			if (halted) begin
				halt_age++;
				if (wake)
					halted = 1'b0;
				else if (halt_age >= 2 && memory_valid)
					report_rule("request issued while halted");
			end
			if (is_executing && halt) begin
				halted   = 1'b1;
				halt_age = 0;
			end
		end
	end

endmodule

// File: rtl/slurm16_memory_top.sv
// slurm16 memory system top level
// CPU memory interface and arbiter joined by the memory bus,
// with the bus brought out as plain ports

`timescale 1ns/1ps

`include "slurm16_cfg.svh"

module slurm16_memory_top (
	input  logic                             CLK,
	input  logic                             RSTb,
	input  logic                             load_memory,
	input  logic                             store_memory,
	input  logic                             halt,
	input  logic                             wake,
	input  logic [`SLURM16_ADDRESS_BITS-1:0] pc,
	input  logic [`SLURM16_ADDRESS_BITS-1:0] load_store_address,
	input  logic [`SLURM16_ADDRESS_BITS-1:0] store_memory_data,
	input  slurm16_mem_pkg::wr_mask_t        store_memory_wr_mask,
	input  logic [`SLURM16_BANKS-1:0]        bank_busy,

	output logic                             is_executing,
	output logic                             is_fetching,
	output logic                             memory_is_instruction,
	output logic                             stall_memory_pipeline_stage3,
	output logic [`SLURM16_ADDRESS_BITS-1:0] memory_address_prev_plus_two,
	output slurm16_mem_pkg::wr_mask_t        memory_wr_mask_delayed,

	output logic [`SLURM16_ADDRESS_BITS-1:0] memory_address,
	output logic                             memory_valid,
	output logic                             memory_ready,
	output logic                             memory_wr,
	output slurm16_mem_pkg::wr_mask_t        memory_wr_mask,
	output logic [`SLURM16_BITS-1:0]         memory_out,
	output logic [`SLURM16_BITS-1:0]         memory_rdata
);

	slurm16_mem_if mem_bus ();

	slurm16_cpu_memory_interface u_cpu_mem (
		.CLK                          (CLK),
		.RSTb                         (RSTb),
		.load_memory                  (load_memory),
		.store_memory                 (store_memory),
		.halt                         (halt),
		.wake                         (wake),
		.pc                           (pc),
		.load_store_address           (load_store_address),
		.store_memory_data            (store_memory_data),
		.store_memory_wr_mask         (store_memory_wr_mask),
		.mem                          (mem_bus.cpu),
		.is_executing                 (is_executing),
		.is_fetching                  (is_fetching),
		.memory_is_instruction        (memory_is_instruction),
		.stall_memory_pipeline_stage3 (stall_memory_pipeline_stage3),
		.memory_address_prev_plus_two (memory_address_prev_plus_two),
		.memory_wr_mask_delayed       (memory_wr_mask_delayed)
	);

	slurm16_memory_arbiter u_arbiter (
		.CLK       (CLK),
		.RSTb      (RSTb),
		.mem       (mem_bus.arb),
		.bank_busy (bank_busy)
	);

	// Bus observed at the top
	assign memory_address = mem_bus.address;
	assign memory_valid   = mem_bus.valid;
	assign memory_ready   = mem_bus.ready;
	assign memory_wr      = mem_bus.wr;
	assign memory_wr_mask = mem_bus.wr_mask;
	assign memory_out     = mem_bus.wdata;
	assign memory_rdata   = mem_bus.rdata;

endmodule

// File: rtl/slurm16_cpu_memory_interface.sv
// slurm16 CPU memory interface
// Sequences instruction fetches, data loads and data stores over the
// request/grant bus. Memory is split into banks by the top address bit,
// and every change of bank inserts two wait states before the access.

`timescale 1ns/1ps

`include "slurm16_cfg.svh"

module slurm16_cpu_memory_interface (
	input  logic                             CLK,
	input  logic                             RSTb,

	input  logic                             load_memory,   // Load next
	input  logic                             store_memory,  // Store next
	input  logic                             halt,
	input  logic                             wake,

	input  logic [`SLURM16_ADDRESS_BITS-1:0] pc,
	input  logic [`SLURM16_ADDRESS_BITS-1:0] load_store_address,
	input  logic [`SLURM16_ADDRESS_BITS-1:0] store_memory_data,
	input  slurm16_mem_pkg::wr_mask_t        store_memory_wr_mask,

	slurm16_mem_if.cpu                       mem,

	output logic                             is_executing,
	output logic                             is_fetching,
	output logic                             memory_is_instruction,
	output logic                             stall_memory_pipeline_stage3,
	output logic [`SLURM16_ADDRESS_BITS-1:0] memory_address_prev_plus_two,
	output slurm16_mem_pkg::wr_mask_t        memory_wr_mask_delayed
);

	localparam int AW = `SLURM16_ADDRESS_BITS;

	slurm16_cpu_pkg::cpu_state_t cpu_state_r, cpu_state_next;

	logic [AW-1:0] addr_r;       // Byte address on the bus
	logic [AW-1:0] prev_addr_r;  // Address of the previous advance
	logic [AW-1:0] next_addr;
	logic [AW-1:0] prev_plus_two_r;

	logic [`SLURM16_BITS-1:0]  memory_out_r;
	slurm16_mem_pkg::wr_mask_t memory_wr_mask_r;
	slurm16_mem_pkg::wr_mask_t memory_wr_mask_del_r;

	logic memory_is_instruction_r, memory_is_instruction_next;
	logic preserve_addr;  // Hold address while a bank switch is pending
	logic valid, wr;

	// True when two byte addresses fall in different banks
	function automatic logic has_bank_switch(input logic [AW-1:0] a, input logic [AW-1:0] b);
		return a[AW-1] ^ b[AW-1];
	endfunction

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			cpu_state_r             <= slurm16_cpu_pkg::cpust_wait_mem_ready1;
			addr_r                  <= '0;
			prev_addr_r             <= '0;
			memory_wr_mask_r        <= 2'b11;
			memory_wr_mask_del_r    <= 2'b11;
			memory_is_instruction_r <= 1'b0;
		end else begin
			cpu_state_r             <= cpu_state_next;
			memory_is_instruction_r <= memory_is_instruction_next;
			if (!preserve_addr) begin
				addr_r               <= next_addr;
				prev_addr_r          <= addr_r;
				memory_wr_mask_del_r <= memory_wr_mask_r;
				if (is_executing)
					memory_wr_mask_r <= store_memory_wr_mask;
			end
		end
	end

	// Store data follows the address advance
	always_ff @(posedge CLK) begin
		if (!preserve_addr && is_executing)
			memory_out_r <= store_memory_data;
	end

	// Return address for instructions
	always_ff @(posedge CLK) begin
		prev_plus_two_r <= addr_r + {{(AW-2){1'b0}}, 2'b10};
	end

	always_comb begin
		cpu_state_next             = cpu_state_r;
		memory_is_instruction_next = memory_is_instruction_r;
		preserve_addr              = 1'b0;

		case (cpu_state_r)
			slurm16_cpu_pkg::cpust_halt:
				if (wake)
					cpu_state_next = slurm16_cpu_pkg::cpust_wait_mem_ready1;
			slurm16_cpu_pkg::cpust_execute: begin
				memory_is_instruction_next = 1'b1;
				if (halt)
					cpu_state_next = slurm16_cpu_pkg::cpust_halt;
				else if (load_memory)
					cpu_state_next = has_bank_switch(addr_r, prev_addr_r) ?
						slurm16_cpu_pkg::cpust_wait_mem_load1 :
						slurm16_cpu_pkg::cpust_execute_load;
				else if (store_memory)
					cpu_state_next = has_bank_switch(addr_r, prev_addr_r) ?
						slurm16_cpu_pkg::cpust_wait_mem_store1 :
						slurm16_cpu_pkg::cpust_execute_store;
				else if (has_bank_switch(addr_r, prev_addr_r))
					cpu_state_next = slurm16_cpu_pkg::cpust_wait_mem_ready1;
			end
			slurm16_cpu_pkg::cpust_pre_execute:
				cpu_state_next = halt ? slurm16_cpu_pkg::cpust_halt :
					slurm16_cpu_pkg::cpust_execute;
			slurm16_cpu_pkg::cpust_wait_mem_ready1: begin
				cpu_state_next             = slurm16_cpu_pkg::cpust_wait_mem_ready2;
				memory_is_instruction_next = 1'b0;
			end
			slurm16_cpu_pkg::cpust_wait_mem_ready2: begin
				if (mem.ready)
					cpu_state_next = slurm16_cpu_pkg::cpust_execute;
				memory_is_instruction_next = 1'b0;
			end
			slurm16_cpu_pkg::cpust_wait_mem_ready1_2: begin
				cpu_state_next             = slurm16_cpu_pkg::cpust_wait_mem_ready2_2;
				memory_is_instruction_next = 1'b0;
			end
			slurm16_cpu_pkg::cpust_wait_mem_ready2_2:
				if (mem.ready)
					cpu_state_next = slurm16_cpu_pkg::cpust_pre_execute;
			slurm16_cpu_pkg::cpust_execute_load: begin
				memory_is_instruction_next = 1'b0;
				if (halt)
					cpu_state_next = slurm16_cpu_pkg::cpust_halt;
				else if (has_bank_switch(addr_r, prev_addr_r)) begin
					cpu_state_next = slurm16_cpu_pkg::cpust_wait_mem_load1;
					preserve_addr  = 1'b1;
				end else if (store_memory)
					cpu_state_next = has_bank_switch(pc, prev_addr_r) ?
						slurm16_cpu_pkg::cpust_wait_mem_store1 :
						slurm16_cpu_pkg::cpust_execute_store;
				else if (!load_memory)
					cpu_state_next = has_bank_switch(addr_r, pc) ?
						slurm16_cpu_pkg::cpust_wait_mem_ready1_2 :
						slurm16_cpu_pkg::cpust_execute;
			end
			slurm16_cpu_pkg::cpust_wait_mem_load1:
				cpu_state_next = slurm16_cpu_pkg::cpust_wait_mem_load2;
			slurm16_cpu_pkg::cpust_wait_mem_load2:
				if (mem.ready)
					cpu_state_next = slurm16_cpu_pkg::cpust_execute_load;
			slurm16_cpu_pkg::cpust_execute_store: begin
				memory_is_instruction_next = 1'b0;
				if (halt)
					cpu_state_next = slurm16_cpu_pkg::cpust_halt;
				else if (has_bank_switch(addr_r, prev_addr_r)) begin
					cpu_state_next = slurm16_cpu_pkg::cpust_wait_mem_store1;
					preserve_addr  = 1'b1;
				end else if (load_memory)
					cpu_state_next = has_bank_switch(pc, prev_addr_r) ?
						slurm16_cpu_pkg::cpust_wait_mem_load1 :
						slurm16_cpu_pkg::cpust_execute_load;
				else if (!store_memory)
					cpu_state_next = has_bank_switch(addr_r, pc) ?
						slurm16_cpu_pkg::cpust_wait_mem_ready1_2 :
						slurm16_cpu_pkg::cpust_execute;
			end
			slurm16_cpu_pkg::cpust_wait_mem_store1:
				cpu_state_next = slurm16_cpu_pkg::cpust_wait_mem_store2;
			slurm16_cpu_pkg::cpust_wait_mem_store2:
				if (mem.ready)
					cpu_state_next = slurm16_cpu_pkg::cpust_execute_store;
			default:
				cpu_state_next = slurm16_cpu_pkg::cpust_halt;
		endcase
	end

	always_comb begin
		is_executing = 1'b0;
		case (cpu_state_r)
			slurm16_cpu_pkg::cpust_execute,
			slurm16_cpu_pkg::cpust_pre_execute,
			slurm16_cpu_pkg::cpust_execute_load,
			slurm16_cpu_pkg::cpust_execute_store:
				is_executing = 1'b1;
			default: ;
		endcase
	end

	assign is_fetching = (cpu_state_next == slurm16_cpu_pkg::cpust_execute) &&
		!has_bank_switch(addr_r, pc);

	// Address advances only while executing
	always_comb begin
		next_addr = addr_r;
		if (is_executing)
			next_addr = (load_memory || store_memory) ? load_store_address : pc;
	end

	always_comb begin
		valid = 1'b0;
		wr    = 1'b0;
		case (cpu_state_r)
			slurm16_cpu_pkg::cpust_execute,
			slurm16_cpu_pkg::cpust_pre_execute,
			slurm16_cpu_pkg::cpust_wait_mem_ready2,
			slurm16_cpu_pkg::cpust_wait_mem_ready2_2,
			slurm16_cpu_pkg::cpust_execute_load,
			slurm16_cpu_pkg::cpust_wait_mem_load2:
				valid = 1'b1;
			slurm16_cpu_pkg::cpust_execute_store,
			slurm16_cpu_pkg::cpust_wait_mem_store2: begin
				valid = 1'b1;
				wr    = !has_bank_switch(addr_r, prev_addr_r);  // No write into old bank
			end
			default: ;
		endcase
	end

	assign mem.address = {1'b0, addr_r[AW-1:1]};  // Word address
	assign mem.valid   = valid;
	assign mem.wr      = wr;
	assign mem.wr_mask = memory_wr_mask_r;
	assign mem.wdata   = memory_out_r;

	assign memory_is_instruction        = memory_is_instruction_r;
	assign stall_memory_pipeline_stage3 = preserve_addr;
	assign memory_address_prev_plus_two = prev_plus_two_r;
	assign memory_wr_mask_delayed       = memory_wr_mask_del_r;

	// A refused request keeps its wait state and its address
	a_hold_on_backpressure: assert property (@(posedge CLK) disable iff (!RSTb)
		(mem.valid && !mem.ready && !is_executing) |=>
			$stable(cpu_state_r) && $stable(addr_r));

	// Requests are off by the second cycle after a halt is taken
	a_halt_stops_requests: assert property (@(posedge CLK) disable iff (!RSTb)
		(is_executing && halt) |=> ##1 !mem.valid);

endmodule

// File: rtl/slurm16_memory_arbiter.sv
// slurm16 memory arbiter
// Grants each request unless the addressed bank is held by an outside
// agent, steers writes to the addressed bank and returns read data from
// the bank that was read in the previous cycle

`timescale 1ns/1ps

`include "slurm16_cfg.svh"

module slurm16_memory_arbiter (
	input  logic                      CLK,
	input  logic                      RSTb,
	slurm16_mem_if.arb                mem,
	input  logic [`SLURM16_BANKS-1:0] bank_busy  // Bank held by outside agent
);

	localparam int WORD_BITS = $clog2(`SLURM16_BANK_WORDS);
	localparam int BANK_BIT  = `SLURM16_ADDRESS_BITS - 2;  // Word address bank bit

	slurm16_mem_pkg::bank_t   bank_sel;
	slurm16_mem_pkg::bank_t   rd_bank_r;  // Bank of the last granted read
	logic                     grant;
	logic [`SLURM16_BITS-1:0] bank_rdata [`SLURM16_BANKS];

	assign bank_sel  = mem.address[BANK_BIT];
	assign grant     = mem.valid && !bank_busy[bank_sel];
	assign mem.ready = grant;

	always_ff @(posedge CLK) begin
		if (!RSTb)
			rd_bank_r <= '0;
		else if (grant && !mem.wr)
			rd_bank_r <= bank_sel;
	end

	assign mem.rdata = bank_rdata[rd_bank_r];

	for (genvar b = 0; b < `SLURM16_BANKS; b++) begin : g_bank
		slurm16_memory_bank u_bank (
			.CLK     (CLK),
			.en      (grant && (bank_sel == b)),
			.wr      (mem.wr),
			.addr    (mem.address[WORD_BITS-1:0]),  // Upper bits alias
			.wdata   (mem.wdata),
			.wr_mask (mem.wr_mask),
			.rdata   (bank_rdata[b])
		);
	end

endmodule

// File: rtl/slurm16_memory_bank.sv
// slurm16 memory bank
// Synchronous word RAM with byte write enables and a one-cycle read

`timescale 1ns/1ps

`include "slurm16_cfg.svh"

module slurm16_memory_bank (
	input  logic                                     CLK,
	input  logic                                     en,       // Access this cycle
	input  logic                                     wr,
	input  logic [$clog2(`SLURM16_BANK_WORDS)-1:0]   addr,     // Word index
	input  logic [`SLURM16_BITS-1:0]                 wdata,
	input  slurm16_mem_pkg::wr_mask_t                wr_mask,
	output logic [`SLURM16_BITS-1:0]                 rdata
);

	localparam int BYTES = `SLURM16_BITS / 8;

	logic [`SLURM16_BITS-1:0] ram [`SLURM16_BANK_WORDS] = '{default: '0};  // Contents start cleared

	always_ff @(posedge CLK) begin
		if (en) begin
			if (wr) begin
				for (int b = 0; b < BYTES; b++) begin
					if (wr_mask[b])
						ram[addr][b*8 +: 8] <= wdata[b*8 +: 8];
				end
			end
			rdata <= ram[addr];  // Old contents on a write
		end
	end

endmodule

// File: rtl/slurm16_mem_if.sv
// slurm16 memory bus
// Request/grant bus between the CPU memory interface and the arbiter
// An access happens in every cycle where valid and ready are both high
// Read data follows one cycle after a granted read

`timescale 1ns/1ps

`include "slurm16_cfg.svh"

interface slurm16_mem_if;

	logic [`SLURM16_ADDRESS_BITS-1:0] address;  // Word address
	logic                             valid;    // Request
	logic                             wr;       // Write when high, read when low
	slurm16_mem_pkg::wr_mask_t        wr_mask;  // Byte enables of a write
	logic [`SLURM16_BITS-1:0]         wdata;    // Write data
	logic                             ready;    // Grant
	logic [`SLURM16_BITS-1:0]         rdata;    // Read data, one cycle after grant

	// CPU side, issues requests
	modport cpu (
		output address, valid, wr, wr_mask, wdata,
		input  ready, rdata
	);

	// Arbiter side, grants and returns data
	modport arb (
		input  address, valid, wr, wr_mask, wdata,
		output ready, rdata
	);

endinterface

// File: rtl/slurm16_mem_pkg.sv
// slurm16 memory-side types
// Bank index and byte write mask carried on the memory bus

package slurm16_mem_pkg;

	// Index of a memory bank, taken from the top word address bit
	typedef logic bank_t;

	// Byte enables of a word write
	// Bit 0 enables the low byte, bit 1 the high byte
	typedef logic [1:0] wr_mask_t;

endpackage

// File: rtl/slurm16_cpu_pkg.sv
// slurm16 CPU-side types
// State encoding of the fetch/load/store sequencer in the memory interface

package slurm16_cpu_pkg;

	// Sequencer states, encodings are dense from 0 to 12
	typedef enum logic [3:0] {
		cpust_halt              = 4'd0,  // Halted, no fetches
		cpust_execute           = 4'd1,  // Executing, fetching instructions
		cpust_wait_mem_ready1   = 4'd2,  // Bank switch wait before fetch
		cpust_wait_mem_ready2   = 4'd3,  // Waiting for grant on new fetch bank
		cpust_execute_load      = 4'd4,  // Load in progress
		cpust_wait_mem_load1    = 4'd5,  // Bank switch wait before load
		cpust_wait_mem_load2    = 4'd6,  // Waiting for grant on load bank
		cpust_execute_store     = 4'd7,  // Store in progress
		cpust_wait_mem_store1   = 4'd8,  // Bank switch wait before store
		cpust_wait_mem_store2   = 4'd9,  // Waiting for grant on store bank
		cpust_pre_execute       = 4'd10, // One fetch before resuming execute
		cpust_wait_mem_ready1_2 = 4'd11, // Bank switch wait after load/store
		cpust_wait_mem_ready2_2 = 4'd12  // Grant wait after load/store
	} cpu_state_t;

endpackage

// File: rtl/slurm16_cfg.svh
// slurm16 memory system configuration
// Word, address and bank geometry shared by the memory interface,
// the arbiter and the banks

`ifndef SLURM16_CFG_SVH
`define SLURM16_CFG_SVH

// Data word width in bits
`define SLURM16_BITS 16

// Byte address width in bits
// The top byte address bit selects the bank
`define SLURM16_ADDRESS_BITS 16

// Number of memory banks
`define SLURM16_BANKS 2

// Words actually stored per bank
// Word address bits above the index and below the bank bit alias
`define SLURM16_BANK_WORDS 256

`endif
